/* test/timing_core_stimulus.txt */
# stream: W k(hex) data(hex) tag | I idle_cycles | B secs(hex) | C sel_code(hex) | D oc_delay
# checks: T name secs(hex) | N name count drops | L name addr(hex) kind code(hex) tag | O name hb_tag n rec_tag
C 20
D 5
I 4
W 0 0020 0
W 0 0020 0
I 4
N gate_before_valid 0 0
B 1234ABCD
W 0 007D 0
I 10
T timestamp 1234ABCD
W 0 0020 1
W 1 0020 0
W 0 0031 0
I 6
N event_count 1 0
L event_record 00 0 20 1
W 0 007A 2
I 75
W 0 007A 3
O orbit_delay5 3 0 7
D 20
O orbit_delay20 3 1 8
I 73
W 0 0020 4
O shared_trigger 3 2 9
I 8
N shared_count 2 0
L shared_event 01 0 20 4
L shared_orbit 13 1 7A 9
W 0 0020 6
W 0 0020 0
I 8
N backpressure_count 4 1
L backpressure_record 02 0 20 6
L orbit_delay5_record 11 1 7A 7
L orbit_delay20_record 12 1 7A 8

/* timing_core.f */
+incdir+include
src/evr_pkg.sv
src/evr_rx_decoder.sv
src/event_logger.sv
src/orbit_trigger.sv
src/wb_arbiter.sv
src/event_log_ram.sv
src/timing_core.sv
test/timing_core_chk.sv
test/timing_core_tb.sv

/* Makefile */
VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := timing_core_tb
FILELIST  := timing_core.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q "PASS: all tests" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* test/timing_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "evr_settings.svh"

module timing_core_tb;

    localparam int          OC_PERIOD    = `EVR_HARMONIC_N / 4;
    localparam int          TRIG_TIMEOUT = 300;
    localparam int          RUN_LIMIT    = 20000;
    localparam logic [15:0] IDLE_DATA    = {8'h00, `EVR_K_COMMA};

    logic                       evr_clk;
    logic                       i_rst_n;
    evr_pkg::evr_word_t         i_rxd;
    logic [7:0]                 i_sel_code;
    logic [`EVR_OC_DELAY_W-1:0] i_oc_delay;
    logic [`EVR_LOG_AW-1:0]     i_rd_addr;
    evr_pkg::evr_ts_t           o_ts;
    logic                       o_ts_valid;
    logic                       o_event;
    logic [31:0]                o_event_cnt;
    logic [15:0]                o_drop_cnt;
    logic                       o_oc_valid;
    logic                       o_oc_trig;
    evr_pkg::evr_ts_t           o_oc_ts;
    evr_pkg::log_rec_t          o_rd_data;

    // reference model of the stream timestamp
    int          cyc = 0;
    int          pps_edge;
    logic [31:0] secs_sr;
    logic [31:0] secs_model;
    // per tag, the edge that sampled the word and the ticks its record should carry
    int          tag_edge [16];
    logic [31:0] tag_ticks [16];
    // word on the stream carries the selected code
    logic        sel_word;
    logic        event_due;

    int errors;
    int test_errs;
    int tests_run;
    int tests_failed;

    timing_core i_dut (
        .evr_clk     (evr_clk),
        .i_rst_n     (i_rst_n),
        .i_rxd       (i_rxd),
        .i_sel_code  (i_sel_code),
        .i_oc_delay  (i_oc_delay),
        .i_rd_addr   (i_rd_addr),
        .o_ts        (o_ts),
        .o_ts_valid  (o_ts_valid),
        .o_event     (o_event),
        .o_event_cnt (o_event_cnt),
        .o_drop_cnt  (o_drop_cnt),
        .o_oc_valid  (o_oc_valid),
        .o_oc_trig   (o_oc_trig),
        .o_oc_ts     (o_oc_ts),
        .o_rd_data   (o_rd_data)
    );

    initial begin
        evr_clk = 1'b0;
        forever #5 evr_clk = ~evr_clk;
    end

    always @(posedge evr_clk) begin
        cyc <= cyc + 1;
    end

    // o_event shows the selected code in the cycle after its word is sampled
    always @(posedge evr_clk) begin
        event_due <= sel_word;
    end

    always @(negedge evr_clk) begin
        if (i_rst_n) begin
            assert (o_event === event_due) else begin
                $display("[ERROR] %0t ns: event is %0b, expected %0b",
                         $time, o_event, event_due);
                test_errs++;
            end
        end
    end

    // ------------------------------
    // stimulus helpers
    // ------------------------------
    task automatic tick_cycle();
        @(posedge evr_clk);
        #1;
    endtask

    // drives one word and keeps the seconds model in step with it
    task automatic put_word(input logic [1:0] k, input logic [15:0] data);
        i_rxd.k    = k;
        i_rxd.data = data;
        sel_word   = !k[0] && (data[7:0] != 8'h00) && (data[7:0] == i_sel_code);
        if (!k[0]) begin
            if (data[7:0] == `EVR_EVCODE_SEC0 || data[7:0] == `EVR_EVCODE_SEC1) begin
                secs_sr = {secs_sr[30:0], data[7:0] == `EVR_EVCODE_SEC1};
            end else if (data[7:0] == `EVR_EVCODE_PPS) begin
                secs_model = secs_sr;
                // sampled at the next edge, ticks count from there
                pps_edge = cyc + 1;
            end
        end
    endtask

    task automatic send_word(input logic [1:0] k, input logic [15:0] data);
        tick_cycle();
        put_word(k, data);
    endtask

    task automatic send_idle(input int n);
        for (int i = 0; i < n; i++) begin
            send_word(2'b01, IDLE_DATA);
        end
    endtask

    // ------------------------------
    // checking and reporting
    // ------------------------------
    task automatic expect_eq(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
            test_errs++;
        end
    endtask

    task automatic finish_test(input logic [8*32-1:0] name);
        tests_run++;
        if (test_errs != 0) begin
            tests_failed++;
            errors += test_errs;
            $display("test %0s: failed with %0d error(s)", name, test_errs);
        end else begin
            $display("test %0s: ok", name);
        end
        test_errs = 0;
    endtask

    function automatic logic fields_ok(input int got, input int need, input string line);
        if (got != need) begin
            $display("stimulus line has %0d fields instead of %0d: %s", got, need, line);
            errors++;
            return 1'b0;
        end
        return 1'b1;
    endfunction

    // overall cycle limit for the run
    initial begin
        for (int i = 0; i < RUN_LIMIT; i++) begin
            @(posedge evr_clk);
        end
        $display("simulation stopped, stimulus did not finish within %0d cycles", RUN_LIMIT);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        int              fd;
        string           line;
        byte             cmd;
        int              n_args;
        logic [8*32-1:0] name;
        logic [31:0]     a;
        logic [31:0]     b;
        logic [31:0]     c;
        logic [31:0]     d;
        int              due;
        logic            found;

        i_rst_n      = 1'b0;
        i_rxd        = '{k: 2'b01, data: IDLE_DATA};
        i_sel_code   = 8'h00;
        i_oc_delay   = '0;
        i_rd_addr    = '0;
        secs_sr      = '0;
        secs_model   = '0;
        pps_edge     = 0;
        sel_word     = 1'b0;
        errors       = 0;
        test_errs    = 0;
        tests_run    = 0;
        tests_failed = 0;

        for (int i = 0; i < 8; i++) begin
            tick_cycle();
        end
        i_rst_n = 1'b1;

        expect_eq("ts valid", 64'(o_ts_valid), 64'd0);
        expect_eq("oc valid", 64'(o_oc_valid), 64'd0);
        expect_eq("oc trig", 64'(o_oc_trig), 64'd0);
        expect_eq("event", 64'(o_event), 64'd0);
        expect_eq("event count", 64'(o_event_cnt), 64'd0);
        finish_test("reset_state");

        fd = $fopen("test/timing_core_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open test/timing_core_stimulus.txt");
            errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 2 || line.getc(0) == "#") begin
                    continue;
                end
                cmd = line.getc(0);
                case (cmd)
                    "W": begin
                        n_args = $sscanf(line, "W %h %h %d", a, b, c);
                        if (fields_ok(n_args, 3, line)) begin
                            send_word(a[1:0], b[15:0]);
                            if (c != 0) begin
                                tag_edge[c[3:0]]  = cyc + 1;
                                tag_ticks[c[3:0]] = 32'(cyc + 1 - pps_edge);
                            end
                        end
                    end
                    "I": begin
                        n_args = $sscanf(line, "I %d", a);
                        if (fields_ok(n_args, 1, line)) begin
                            send_idle(int'(a));
                        end
                    end
                    "B": begin
                        n_args = $sscanf(line, "B %h", a);
                        if (fields_ok(n_args, 1, line)) begin
                            // msb first, one seconds event per bit
                            for (int i = 31; i >= 0; i--) begin
                                send_word(2'b00, {8'h00, a[i] ? `EVR_EVCODE_SEC1
                                                              : `EVR_EVCODE_SEC0});
                            end
                        end
                    end
                    "C": begin
                        n_args = $sscanf(line, "C %h", a);
                        if (fields_ok(n_args, 1, line)) begin
                            i_sel_code = a[7:0];
                        end
                    end
                    "D": begin
                        n_args = $sscanf(line, "D %d", a);
                        if (fields_ok(n_args, 1, line)) begin
                            i_oc_delay = a[`EVR_OC_DELAY_W-1:0];
                        end
                    end
                    "T": begin
                        n_args = $sscanf(line, "T %s %h", name, a);
                        if (fields_ok(n_args, 2, line)) begin
                            expect_eq("ts valid", 64'(o_ts_valid), 64'd1);
                            expect_eq("ts secs", 64'(o_ts.secs), 64'(a));
                            expect_eq("ts ticks", 64'(o_ts.tcks), 64'(cyc - pps_edge));
                            finish_test(name);
                        end
                    end
                    "N": begin
                        n_args = $sscanf(line, "N %s %d %d", name, a, b);
                        if (fields_ok(n_args, 3, line)) begin
                            expect_eq("event count", 64'(o_event_cnt), 64'(a));
                            expect_eq("drop count", 64'(o_drop_cnt), 64'(b));
                            finish_test(name);
                        end
                    end
                    "L": begin
                        n_args = $sscanf(line, "L %s %h %d %h %d", name, a, b, c, d);
                        if (fields_ok(n_args, 5, line)) begin
                            // registered read port, data one cycle after the address
                            i_rd_addr = a[`EVR_LOG_AW-1:0];
                            send_idle(1);
                            expect_eq("record kind", 64'(o_rd_data.kind), 64'(b));
                            expect_eq("record code", 64'(o_rd_data.code), 64'(c));
                            expect_eq("record secs", 64'(o_rd_data.ts.secs), 64'(secs_model));
                            expect_eq("record ticks", 64'(o_rd_data.ts.tcks),
                                      64'(tag_ticks[d[3:0]]));
                            finish_test(name);
                        end
                    end
                    "O": begin
                        n_args = $sscanf(line, "O %s %d %d %d", name, a, b, c);
                        if (fields_ok(n_args, 4, line)) begin
                            // edge the cycle after the heartbeat is decoded, then every period
                            due = tag_edge[a[3:0]] + 1 + OC_PERIOD * int'(b)
                                  + int'(i_oc_delay);
                            found = 1'b0;
                            for (int i = 0; i < TRIG_TIMEOUT && !found; i++) begin
                                tick_cycle();
                                found = o_oc_trig;
                                put_word(2'b01, IDLE_DATA);
                            end
                            if (!found) begin
                                $display("no orbit trigger within %0d cycles in test %0s",
                                         TRIG_TIMEOUT, name);
                                test_errs++;
                            end else begin
                                expect_eq("trigger cycle", 64'(cyc), 64'(due));
                                expect_eq("oc valid", 64'(o_oc_valid), 64'd1);
                                tag_ticks[c[3:0]] = 32'(due - pps_edge);
                                send_idle(1);
                                expect_eq("oc ts secs", 64'(o_oc_ts.secs), 64'(secs_model));
                                expect_eq("oc ts ticks", 64'(o_oc_ts.tcks),
                                          64'(tag_ticks[c[3:0]]));
                            end
                            finish_test(name);
                        end
                    end
                    default: begin
                        $display("unknown stimulus command: %s", line);
                        errors++;
                    end
                endcase
            end
            $fclose(fd);
        end

        $display("tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* test/timing_core_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module timing_core_chk (
    input wire                   evr_clk,
    input wire                   i_rst_n,
    input wire evr_pkg::wb_req_t i_m0_req,
    input wire evr_pkg::wb_req_t i_m1_req,
    input wire evr_pkg::wb_req_t i_s_req,
    input wire evr_pkg::wb_rsp_t i_m0_rsp,
    input wire evr_pkg::wb_rsp_t i_m1_rsp,
    input wire                   i_oc_trig
);

    // ------------------------------
    // wishbone handshake
    // ------------------------------
    a_stb_with_cyc: assert property (@(posedge evr_clk) disable iff (!i_rst_n)
        (!i_m0_req.stb || i_m0_req.cyc) && (!i_m1_req.stb || i_m1_req.cyc) &&
        (!i_s_req.stb || i_s_req.cyc))
        else $error("wishbone stb high without cyc");

    // ack goes only to the granted master
    a_single_ack: assert property (@(posedge evr_clk) disable iff (!i_rst_n)
        !(i_m0_rsp.ack && i_m1_rsp.ack) &&
        (!i_m0_rsp.ack || i_m0_req.cyc) && (!i_m1_rsp.ack || i_m1_req.cyc))
        else $error("ack given to both masters or to a master without a cycle");

    // ------------------------------
    // orbit trigger
    // ------------------------------
    a_trig_pulse: assert property (@(posedge evr_clk) disable iff (!i_rst_n)
        i_oc_trig |=> !i_oc_trig)
        else $error("orbit trigger longer than one cycle");

endmodule

bind timing_core timing_core_chk u_chk (
    .evr_clk   (evr_clk),
    .i_rst_n   (i_rst_n),
    .i_m0_req  (log_req),
    .i_m1_req  (oc_req),
    .i_s_req   (ram_req),
    .i_m0_rsp  (log_rsp),
    .i_m1_rsp  (oc_rsp),
    .i_oc_trig (o_oc_trig)
);

`default_nettype wire

/* src/timing_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "evr_settings.svh"

module timing_core (
    input  wire                evr_clk,
    input  wire                i_rst_n,
    input  wire evr_pkg::evr_word_t i_rxd,
    input  wire [7:0]          i_sel_code,
    input  wire [`EVR_OC_DELAY_W-1:0] i_oc_delay,
    input  wire [`EVR_LOG_AW-1:0] i_rd_addr,
    output evr_pkg::evr_ts_t   o_ts,
    output logic               o_ts_valid,
    output logic               o_event,
    output logic [31:0]        o_event_cnt,
    output logic [15:0]        o_drop_cnt,
    output logic               o_oc_valid,
    output logic               o_oc_trig,
    output evr_pkg::evr_ts_t   o_oc_ts,
    output evr_pkg::log_rec_t  o_rd_data
);

    logic [7:0]       evcode;
    logic             evstrobe;
    logic             heartbeat;
    evr_pkg::wb_req_t log_req;
    evr_pkg::wb_rsp_t log_rsp;
    evr_pkg::wb_req_t oc_req;
    evr_pkg::wb_rsp_t oc_rsp;
    evr_pkg::wb_req_t ram_req;
    evr_pkg::wb_rsp_t ram_rsp;

    // ------------------------------
    // stream decode
    // ------------------------------
    evr_rx_decoder u_decoder (
        .evr_clk     (evr_clk),
        .i_rst_n     (i_rst_n),
        .i_rxd       (i_rxd),
        .o_evcode    (evcode),
        .o_evstrobe  (evstrobe),
        .o_pps       (),
        .o_heartbeat (heartbeat),
        .o_ts        (o_ts),
        .o_ts_valid  (o_ts_valid)
    );

    // ------------------------------
    // log writers
    // ------------------------------
    event_logger u_logger (
        .evr_clk     (evr_clk),
        .i_rst_n     (i_rst_n),
        .i_evcode    (evcode),
        .i_evstrobe  (evstrobe),
        .i_ts        (o_ts),
        .i_ts_valid  (o_ts_valid),
        .i_sel_code  (i_sel_code),
        .i_wb_rsp    (log_rsp),
        .o_event     (o_event),
        .o_event_cnt (o_event_cnt),
        .o_drop_cnt  (o_drop_cnt),
        .o_wb_req    (log_req)
    );

    orbit_trigger u_orbit (
        .evr_clk     (evr_clk),
        .i_rst_n     (i_rst_n),
        .i_heartbeat (heartbeat),
        .i_ts        (o_ts),
        .i_oc_delay  (i_oc_delay),
        .i_wb_rsp    (oc_rsp),
        .o_oc_valid  (o_oc_valid),
        .o_oc_trig   (o_oc_trig),
        .o_oc_ts     (o_oc_ts),
        .o_wb_req    (oc_req)
    );

    // ------------------------------
    // shared log memory
    // ------------------------------
    wb_arbiter u_arbiter (
        .evr_clk  (evr_clk),
        .i_rst_n  (i_rst_n),
        .i_m0_req (log_req),
        .i_m1_req (oc_req),
        .i_s_rsp  (ram_rsp),
        .o_m0_rsp (log_rsp),
        .o_m1_rsp (oc_rsp),
        .o_s_req  (ram_req)
    );

    event_log_ram u_log_ram (
        .evr_clk   (evr_clk),
        .i_rst_n   (i_rst_n),
        .i_wb_req  (ram_req),
        .i_rd_addr (i_rd_addr),
        .o_wb_rsp  (ram_rsp),
        .o_rd_data (o_rd_data)
    );

endmodule

`default_nettype wire

/* src/event_log_ram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "evr_settings.svh"

module event_log_ram (
    input  wire                evr_clk,
    input  wire                i_rst_n,
    input  wire evr_pkg::wb_req_t i_wb_req,
    input  wire [`EVR_LOG_AW-1:0] i_rd_addr,
    output evr_pkg::wb_rsp_t   o_wb_rsp,
    output evr_pkg::log_rec_t  o_rd_data
);

    localparam int N_REC = 2 * `EVR_LOG_DEPTH;

    evr_pkg::log_rec_t mem [N_REC];
    logic              accept;

    // a cycle is taken once, the ack cycle itself is not accepted again
    assign accept = i_wb_req.cyc && i_wb_req.stb && !o_wb_rsp.ack;

    always_ff @(posedge evr_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_wb_rsp <= '0;
        end else begin
            o_wb_rsp <= '{ack: accept};
        end
    end

    // ------------------------------
    // storage and readback port
    // ------------------------------
    always_ff @(posedge evr_clk) begin
        if (accept && i_wb_req.we) begin
            mem[i_wb_req.adr] <= i_wb_req.dat;
        end
        o_rd_data <= mem[i_rd_addr];
    end

endmodule

`default_nettype wire

/* src/wb_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_arbiter (
    input  wire                evr_clk,
    input  wire                i_rst_n,
    input  wire evr_pkg::wb_req_t i_m0_req,
    input  wire evr_pkg::wb_req_t i_m1_req,
    input  wire evr_pkg::wb_rsp_t i_s_rsp,
    output evr_pkg::wb_rsp_t   o_m0_rsp,
    output evr_pkg::wb_rsp_t   o_m1_rsp,
    output evr_pkg::wb_req_t   o_s_req
);

    logic locked;
    logic owner;
    logic last_win;
    // 0 selects master 0, 1 selects master 1
    logic sel;

    // ------------------------------
    // grant selection
    // ------------------------------
    always_comb begin
        if (locked) begin
            sel = owner;
        end else if (i_m0_req.cyc && i_m1_req.cyc) begin
            // tie goes to whoever did not win last
            sel = !last_win;
        end else begin
            sel = i_m1_req.cyc;
        end
    end

    assign o_s_req  = sel ? i_m1_req : i_m0_req;
    assign o_m0_rsp = '{ack: i_s_rsp.ack && !sel};
    assign o_m1_rsp = '{ack: i_s_rsp.ack && sel};

    // grant stays with one master from cyc until its ack
    always_ff @(posedge evr_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            locked   <= 1'b0;
            owner    <= 1'b0;
            last_win <= 1'b1;
        end else if (!locked) begin
            if (o_s_req.cyc) begin
                locked   <= 1'b1;
                owner    <= sel;
                last_win <= sel;
            end
        end else if (i_s_rsp.ack) begin
            locked <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* src/orbit_trigger.sv */
`timescale 1ns/1ps
`default_nettype none

`include "evr_settings.svh"

module orbit_trigger (
    input  wire                evr_clk,
    input  wire                i_rst_n,
    input  wire                i_heartbeat,
    input  wire evr_pkg::evr_ts_t i_ts,
    input  wire [`EVR_OC_DELAY_W-1:0] i_oc_delay,
    input  wire evr_pkg::wb_rsp_t i_wb_rsp,
    output logic               o_oc_valid,
    output logic               o_oc_trig,
    output evr_pkg::evr_ts_t   o_oc_ts,
    output evr_pkg::wb_req_t   o_wb_req
);

    localparam int OC_PERIOD = `EVR_HARMONIC_N / 4;
    localparam int PH_W      = $clog2(OC_PERIOD);
    localparam int PTR_W     = `EVR_LOG_AW - 1;

    logic [PH_W-1:0]            phase;
    logic                       phase_last;
    logic                       hb_seen;
    logic                       oc_edge;
    logic                       delay_run;
    logic [`EVR_OC_DELAY_W-1:0] delay_cnt;
    logic                       busy;
    logic [PTR_W-1:0]           wr_ptr;

    // ------------------------------
    // orbit clock recovery
    // ------------------------------
    assign phase_last = (phase == PH_W'(OC_PERIOD - 1));
    // rising edge at phase 0, only once a heartbeat gave us a reference
    assign oc_edge    = hb_seen && (phase == '0);

    always_ff @(posedge evr_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            phase      <= '0;
            hb_seen    <= 1'b0;
            o_oc_valid <= 1'b0;
        end else if (i_heartbeat) begin
            phase   <= '0;
            hb_seen <= 1'b1;
            // aligned when the restart falls on the natural wrap
            if (hb_seen) begin
                o_oc_valid <= phase_last;
            end
        end else if (phase_last) begin
            phase <= '0;
        end else begin
            phase <= phase + PH_W'(1);
        end
    end

    // ------------------------------
    // programmable edge delay
    // ------------------------------
    assign o_oc_trig = (oc_edge && (i_oc_delay == '0)) ||
                       (delay_run && (delay_cnt == i_oc_delay));

    always_ff @(posedge evr_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            delay_run <= 1'b0;
            delay_cnt <= '0;
        end else if (oc_edge) begin
            delay_run <= (i_oc_delay != '0);
            delay_cnt <= `EVR_OC_DELAY_W'(1);
        end else if (delay_run) begin
            if (delay_cnt == i_oc_delay) begin
                delay_run <= 1'b0;
            end else begin
                delay_cnt <= delay_cnt + `EVR_OC_DELAY_W'(1);
            end
        end
    end

    // ------------------------------
    // timestamp capture and log write
    // ------------------------------
    assign busy = o_wb_req.cyc && !i_wb_rsp.ack;

    always_ff @(posedge evr_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_oc_ts  <= '0;
            o_wb_req <= '0;
            wr_ptr   <= '0;
        end else if (o_oc_trig) begin
            // holds the live timestamp of the trigger cycle
            o_oc_ts <= i_ts;
            // record dropped while the previous one waits, trigger still fires
            if (!busy) begin
                o_wb_req.cyc <= 1'b1;
                o_wb_req.stb <= 1'b1;
                o_wb_req.we  <= 1'b1;
                o_wb_req.adr <= {1'b1, wr_ptr};
                o_wb_req.dat <= '{kind: evr_pkg::ORBIT, code: `EVR_EVCODE_HEARTBEAT, ts: i_ts};
                wr_ptr       <= wr_ptr + PTR_W'(1);
            end
        end else if (i_wb_rsp.ack) begin
            o_wb_req.cyc <= 1'b0;
            o_wb_req.stb <= 1'b0;
            o_wb_req.we  <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* src/event_logger.sv */
`timescale 1ns/1ps
`default_nettype none

`include "evr_settings.svh"

module event_logger (
    input  wire                evr_clk,
    input  wire                i_rst_n,
    input  wire [7:0]          i_evcode,
    input  wire                i_evstrobe,
    input  wire evr_pkg::evr_ts_t i_ts,
    input  wire                i_ts_valid,
    input  wire [7:0]          i_sel_code,
    input  wire evr_pkg::wb_rsp_t i_wb_rsp,
    output logic               o_event,
    output logic [31:0]        o_event_cnt,
    output logic [15:0]        o_drop_cnt,
    output evr_pkg::wb_req_t   o_wb_req
);

    localparam int PTR_W = `EVR_LOG_AW - 1;

    logic             match;
    logic             count_event;
    logic             busy;
    logic [PTR_W-1:0] wr_ptr;

    assign match   = i_evstrobe && (i_evcode == i_sel_code);
    assign o_event = match;

    // no counting until the timestamp is recovered, early events may be half decoded
    assign count_event = match && i_ts_valid;

    // an ack in this cycle frees the bus for a new record
    assign busy = o_wb_req.cyc && !i_wb_rsp.ack;

    always_ff @(posedge evr_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_event_cnt <= '0;
            o_drop_cnt  <= '0;
            o_wb_req    <= '0;
            wr_ptr      <= '0;
        end else begin
            if (count_event) begin
                o_event_cnt <= o_event_cnt + 32'd1;
                if (busy) begin
                    o_drop_cnt <= o_drop_cnt + 16'd1;
                end else begin
                    o_wb_req.cyc <= 1'b1;
                    o_wb_req.stb <= 1'b1;
                    o_wb_req.we  <= 1'b1;
                    // lower half of the log belongs to the logger
                    o_wb_req.adr <= {1'b0, wr_ptr};
                    o_wb_req.dat <= '{kind: evr_pkg::EVENT, code: i_evcode, ts: i_ts};
                    wr_ptr       <= wr_ptr + PTR_W'(1);
                end
            end else if (i_wb_rsp.ack) begin
                o_wb_req.cyc <= 1'b0;
                o_wb_req.stb <= 1'b0;
                o_wb_req.we  <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* src/evr_rx_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "evr_settings.svh"

module evr_rx_decoder (
    input  wire                evr_clk,
    input  wire                i_rst_n,
    input  wire evr_pkg::evr_word_t i_rxd,
    output logic [7:0]         o_evcode,
    output logic               o_evstrobe,
    output logic               o_pps,
    output logic               o_heartbeat,
    output evr_pkg::evr_ts_t   o_ts,
    output logic               o_ts_valid
);

    logic [7:0]  code;
    logic        code_ok;
    logic        is_pps;
    logic        is_sec;
    logic [31:0] secs_sr;
    // saturates at 32, enough for a full seconds word
    logic [5:0]  secs_bits;

    // ------------------------------
    // low byte classification
    // ------------------------------
    // K characters are idle, code 0 is no event
    assign code    = i_rxd.data[7:0];
    assign code_ok = !i_rxd.k[0] && (code != 8'h00);
    assign is_pps  = code_ok && (code == `EVR_EVCODE_PPS);
    assign is_sec  = code_ok && ((code == `EVR_EVCODE_SEC0) || (code == `EVR_EVCODE_SEC1));

    always_ff @(posedge evr_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_evcode    <= 8'h00;
            o_evstrobe  <= 1'b0;
            o_pps       <= 1'b0;
            o_heartbeat <= 1'b0;
            o_ts        <= '0;
            o_ts_valid  <= 1'b0;
            secs_sr     <= '0;
            secs_bits   <= '0;
        end else begin
            o_evstrobe  <= code_ok;
            o_evcode    <= code_ok ? code : 8'h00;
            o_pps       <= is_pps;
            o_heartbeat <= code_ok && (code == `EVR_EVCODE_HEARTBEAT);

            if (is_pps) begin
                // new second, ticks restart from zero
                o_ts.secs <= secs_sr;
                o_ts.tcks <= '0;
                secs_bits <= '0;
                if (secs_bits == 6'd32) begin
                    o_ts_valid <= 1'b1;
                end
            end else begin
                o_ts.tcks <= o_ts.tcks + 32'd1;
                if (is_sec) begin
                    // msb first, 0x71 carries a one
                    secs_sr <= {secs_sr[30:0], code == `EVR_EVCODE_SEC1};
                    if (secs_bits != 6'd32) begin
                        secs_bits <= secs_bits + 6'd1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* src/evr_pkg.sv */
`default_nettype none

`include "evr_settings.svh"

package evr_pkg;

    // one stream word, k[0] flags the low byte
    typedef struct packed {
        logic [1:0]  k;
        logic [15:0] data;
    } evr_word_t;

    typedef struct packed {
        logic [31:0] secs;
        logic [31:0] tcks;
    } evr_ts_t;

    typedef enum logic {
        EVENT = 1'b0,
        ORBIT = 1'b1
    } rec_kind_e;

    // 73 bits per record
    typedef struct packed {
        rec_kind_e kind;
        logic [7:0] code;
        evr_ts_t    ts;
    } log_rec_t;

    // ------------------------------
    // wishbone classic
    // ------------------------------
    typedef struct packed {
        logic                   cyc;
        logic                   stb;
        logic                   we;
        logic [`EVR_LOG_AW-1:0] adr;
        log_rec_t               dat;
    } wb_req_t;

    typedef struct packed {
        logic ack;
    } wb_rsp_t;

endpackage

`default_nettype wire

/* include/evr_settings.svh */
`ifndef EVR_SETTINGS_SVH
`define EVR_SETTINGS_SVH

// ------------------------------
// event codes on the timing stream
// ------------------------------
`define EVR_EVCODE_SEC0      8'h70
`define EVR_EVCODE_SEC1      8'h71
`define EVR_EVCODE_HEARTBEAT 8'h7A
`define EVR_EVCODE_PPS       8'h7D
// idle comma, sent as a K character in the low byte
`define EVR_K_COMMA          8'hBC

// ------------------------------
// orbit clock and event log
// ------------------------------
// must be divisible by 4, orbit period is N/4 cycles
`define EVR_HARMONIC_N       304
`define EVR_OC_DELAY_W       7
// records per writer
`define EVR_LOG_DEPTH        16
// top address bit selects the writer half
`define EVR_LOG_AW           ($clog2(2 * `EVR_LOG_DEPTH))

`endif
